// ==== rob_pkg.sv ====
package rob_pkg;

    localparam int ROB_SIZE = 32;
    localparam int ROB_IDX_W = $clog2(ROB_SIZE);
    localparam int DISPATCH_WIDTH = 4;
    // commit window reuses the dispatch slot layout
    localparam int COMMIT_WIDTH = DISPATCH_WIDTH;
    localparam int CNT_W = ROB_IDX_W + 1;
    localparam int NUM_W = 3;
    localparam int EXC_WIDTH = 4;
    localparam logic [EXC_WIDTH-1:0] EXC_NONE = '1;
    localparam int PREG_W = 6;
    localparam int VRD_W = 5;

    // dir flips each time the pointer wraps past the last entry
    typedef struct packed {
        logic                 dir;
        logic [ROB_IDX_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic              we;
        logic              store;
        logic [VRD_W-1:0]  vrd;
        logic [PREG_W-1:0] prd;
        logic [PREG_W-1:0] old_prd;
    } rob_payload_t;

    typedef struct packed {
        logic [NUM_W-1:0]                        valid_num;
        rob_payload_t [DISPATCH_WIDTH-1:0]       payload;
    } dis_req_t;

    typedef struct packed {
        logic                 en;
        rob_idx_t             idx;
        logic [EXC_WIDTH-1:0] exccode;
    } wb_req_t;

    typedef struct packed {
        logic [COMMIT_WIDTH-1:0]             en;
        logic [NUM_W-1:0]                    num;
        rob_idx_t                            idx;
        logic [COMMIT_WIDTH-1:0]             we;
        logic [COMMIT_WIDTH-1:0][VRD_W-1:0]  vrd;
        logic [COMMIT_WIDTH-1:0][PREG_W-1:0] prd;
    } commit_bus_t;

    typedef struct packed {
        logic                 en;
        rob_idx_t             idx;
        logic [EXC_WIDTH-1:0] exccode;
    } exc_report_t;

endpackage

// ==== rob_ctrl.sv ====
`timescale 1ns/1ps

module rob_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  rob_pkg::dis_req_t                   dis,
    input  logic [rob_pkg::NUM_W-1:0]           commit_num,
    output rob_pkg::rob_idx_t                   head,
    output rob_pkg::rob_idx_t                   tail,
    output logic [rob_pkg::CNT_W-1:0]           valid_count,
    output logic                                full,
    output logic [rob_pkg::DISPATCH_WIDTH-1:0]  dispatch_en
);
    import rob_pkg::*;

    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic [CNT_W-1:0] free_count;
    logic [CNT_W-1:0] valid_q;
    logic             dis_accept;
    logic [NUM_W-1:0] add_num;

    // free entries follow from the distance between the pointers
    assign free_count = CNT_W'(ROB_SIZE) - CNT_W'(tail_q - head_q);

    // dispatch is all or nothing for the whole group
    assign full = free_count < CNT_W'(dis.valid_num);
    assign dis_accept = !full && (dis.valid_num != '0);
    assign add_num = dis_accept ? dis.valid_num : '0;

    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            dispatch_en[i] = dis_accept && (dis.valid_num > NUM_W'(i));
        end
    end

    // the top bit of each pointer is its wrap direction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            valid_q <= '0;
        end else begin
            head_q <= head_q + commit_num;
            tail_q <= tail_q + add_num;
            valid_q <= valid_q + CNT_W'(add_num) - CNT_W'(commit_num);
        end
    end

    assign head = head_q;
    assign tail = tail_q;
    assign valid_count = valid_q;

    count_sum_a: assert property (
        @(posedge clk) disable iff (rst)
        (valid_q + free_count) == CNT_W'(ROB_SIZE)
    ) else $error("rob_ctrl: valid and free counts do not add up to ROB_SIZE");

    // commit selection must never retire beyond what is allocated
    commit_bound_a: assert property (
        @(posedge clk) disable iff (rst)
        CNT_W'(commit_num) <= valid_q
    ) else $error("rob_ctrl: commit_num %0d exceeds valid_count %0d", commit_num, valid_q);

endmodule

// ==== rob_payload_ram.sv ====
`timescale 1ns/1ps

module rob_payload_ram (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [rob_pkg::DISPATCH_WIDTH-1:0]         dispatch_en,
    input  rob_pkg::rob_idx_t                          tail,
    input  rob_pkg::dis_req_t                          dis,
    input  rob_pkg::rob_idx_t                          head,
    output rob_pkg::rob_payload_t [rob_pkg::COMMIT_WIDTH-1:0] rdata
);
    import rob_pkg::*;

    rob_payload_t mem [ROB_SIZE];

    // slot i of a dispatch group lands at tail+i
    always_ff @(posedge clk) begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (dispatch_en[i]) begin
                mem[tail.idx + ROB_IDX_W'(i)] <= dis.payload[i];
            end
        end
    end

    // combinational read of the head window
    always_comb begin
        logic [ROB_IDX_W-1:0] raddr;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            raddr = head.idx + ROB_IDX_W'(k);
            rdata[k] = mem[raddr];
        end
    end

    // enables from control must be a run starting at slot 0,
    // otherwise tail+i no longer matches the advance of the tail
    dis_contig_a: assert property (
        @(posedge clk) disable iff (rst)
        ((dispatch_en + 1'b1) & dispatch_en) == '0
    ) else $error("rob_payload_ram: dispatch_en %b is not contiguous", dispatch_en);

endmodule

// ==== rob_status.sv ====
`timescale 1ns/1ps

module rob_status #(
    parameter int WB_PORTS = 3
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  rob_pkg::wb_req_t [WB_PORTS-1:0]            wb,
    input  logic [rob_pkg::DISPATCH_WIDTH-1:0]         dispatch_en,
    input  rob_pkg::rob_idx_t                          tail,
    input  rob_pkg::rob_idx_t                          head,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]           done,
    output logic [rob_pkg::COMMIT_WIDTH-1:0][rob_pkg::EXC_WIDTH-1:0] exccode
);
    import rob_pkg::*;

    logic [ROB_SIZE-1:0]  done_q;
    logic [EXC_WIDTH-1:0] code_q [ROB_SIZE];

    // writeback after allocation so a set would win, though the two never meet
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= '0;
        end else begin
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (dispatch_en[i]) begin
                    done_q[tail.idx + ROB_IDX_W'(i)] <= 1'b0;
                end
            end
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb[p].en) begin
                    done_q[wb[p].idx.idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb[p].en) begin
                code_q[wb[p].idx.idx] <= wb[p].exccode;
            end
        end
    end

    always_comb begin
        logic [ROB_IDX_W-1:0] raddr;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            raddr = head.idx + ROB_IDX_W'(k);
            done[k] = done_q[raddr];
            exccode[k] = code_q[raddr];
        end
    end

    for (genvar p = 0; p < WB_PORTS; p++) begin : g_wb_chk
        wb_once_a: assert property (
            @(posedge clk) disable iff (rst)
            wb[p].en |-> !done_q[wb[p].idx.idx]
        ) else $error("rob_status: port %0d writes back completed entry %0d",
                      p, wb[p].idx.idx);
    end

endmodule

// ==== rob_commit_sel.sv ====
`timescale 1ns/1ps

module rob_commit_sel (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [rob_pkg::CNT_W-1:0]                         valid_count,
    input  rob_pkg::rob_idx_t                                 head,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]                  done,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0][rob_pkg::EXC_WIDTH-1:0] exccode,
    input  rob_pkg::rob_payload_t [rob_pkg::COMMIT_WIDTH-1:0] rdata,
    output logic [rob_pkg::NUM_W-1:0]                         commit_num,
    output rob_pkg::commit_bus_t                              commit,
    output rob_pkg::exc_report_t                              exc
);
    import rob_pkg::*;

    logic [COMMIT_WIDTH-1:0]             slot_en;
    logic [COMMIT_WIDTH-1:0]             slot_exc;
    logic [$clog2(COMMIT_WIDTH)-1:0]     exc_slot;
    logic [COMMIT_WIDTH-1:0]             commit_en_q;
    logic [NUM_W-1:0]                    commit_num_q;
    logic                                exc_en_q;
    rob_idx_t                            commit_idx_q;
    rob_idx_t                            exc_idx_q;
    logic [EXC_WIDTH-1:0]                exc_code_q;
    logic [COMMIT_WIDTH-1:0]             we_q;
    logic [COMMIT_WIDTH-1:0][VRD_W-1:0]  vrd_q;
    logic [COMMIT_WIDTH-1:0][PREG_W-1:0] prd_q;

    // in-order run of completed entries, cut right after the first exception
    always_comb begin
        logic live;
        live = 1'b1;
        commit_num = '0;
        exc_slot = '0;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            slot_en[k] = live && done[k] && (CNT_W'(k) < valid_count);
            slot_exc[k] = slot_en[k] && (exccode[k] != EXC_NONE);
            live = slot_en[k] && !slot_exc[k];
            commit_num = commit_num + NUM_W'(slot_en[k]);
            if (slot_exc[k]) begin
                exc_slot = k[$clog2(COMMIT_WIDTH)-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_en_q <= '0;
            commit_num_q <= '0;
            exc_en_q <= 1'b0;
        end else begin
            commit_en_q <= slot_en;
            commit_num_q <= commit_num;
            exc_en_q <= |slot_exc;
        end
    end

    always_ff @(posedge clk) begin
        commit_idx_q <= head;
        exc_idx_q <= head + exc_slot;
        exc_code_q <= exccode[exc_slot];
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            // the excepting entry retires without writing its register
            we_q[k] <= rdata[k].we && !slot_exc[k];
            vrd_q[k] <= rdata[k].vrd;
            prd_q[k] <= rdata[k].prd;
        end
    end

    always_comb begin
        commit.en = commit_en_q;
        commit.num = commit_num_q;
        commit.idx = commit_idx_q;
        commit.we = we_q;
        commit.vrd = vrd_q;
        commit.prd = prd_q;
        exc.en = exc_en_q;
        exc.idx = exc_idx_q;
        exc.exccode = exc_code_q;
    end

endmodule

// ==== rob_top.sv ====
`timescale 1ns/1ps

module rob_top #(
    parameter int WB_PORTS = 3
) (
    input  logic                             clk,
    input  logic                             rst,
    input  rob_pkg::dis_req_t                dis,
    input  rob_pkg::wb_req_t [WB_PORTS-1:0]  wb,
    output rob_pkg::rob_idx_t                alloc_idx,
    output logic                             full,
    output rob_pkg::commit_bus_t             commit,
    output rob_pkg::exc_report_t             exc
);
    import rob_pkg::*;

    rob_idx_t                               head;
    rob_idx_t                               tail;
    logic [CNT_W-1:0]                       valid_count;
    logic [NUM_W-1:0]                       commit_num;
    logic [DISPATCH_WIDTH-1:0]              dispatch_en;
    rob_payload_t [COMMIT_WIDTH-1:0]        rdata;
    logic [COMMIT_WIDTH-1:0]                done;
    logic [COMMIT_WIDTH-1:0][EXC_WIDTH-1:0] exccode;

    // slot 0 of the next group gets the current tail
    assign alloc_idx = tail;

    rob_ctrl rob_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .dis         (dis),
        .commit_num  (commit_num),
        .head        (head),
        .tail        (tail),
        .valid_count (valid_count),
        .full        (full),
        .dispatch_en (dispatch_en)
    );

    rob_payload_ram rob_payload_ram_i (
        .clk         (clk),
        .rst         (rst),
        .dispatch_en (dispatch_en),
        .tail        (tail),
        .dis         (dis),
        .head        (head),
        .rdata       (rdata)
    );

    rob_status #(
        .WB_PORTS (WB_PORTS)
    ) rob_status_i (
        .clk         (clk),
        .rst         (rst),
        .wb          (wb),
        .dispatch_en (dispatch_en),
        .tail        (tail),
        .head        (head),
        .done        (done),
        .exccode     (exccode)
    );

    rob_commit_sel rob_commit_sel_i (
        .clk         (clk),
        .rst         (rst),
        .valid_count (valid_count),
        .head        (head),
        .done        (done),
        .exccode     (exccode),
        .rdata       (rdata),
        .commit_num  (commit_num),
        .commit      (commit),
        .exc         (exc)
    );

endmodule

// ==== tb_rob.sv ====
`timescale 1ns/1ps

module tb_rob;
    import rob_pkg::*;

    localparam int WB_PORTS = 3;
    localparam int STIM_CYCLES = 1500;
    localparam int DRAIN_LIMIT = 2000;

    typedef struct {
        rob_idx_t             idx;
        rob_payload_t         pl;
        bit                   done;
        logic [EXC_WIDTH-1:0] code;
    } entry_t;

    logic                   clk;
    logic                   rst;
    dis_req_t               dis;
    wb_req_t [WB_PORTS-1:0] wb;
    rob_idx_t               alloc_idx;
    logic                   full;
    commit_bus_t            commit;
    exc_report_t            exc;

    // model of the allocated window, oldest entry first
    entry_t   q[$];
    rob_idx_t mhead;
    rob_idx_t mtail;

    int idx_errs;
    int commit_errs;
    int exc_errs;
    int full_errs;
    int stall_errs;
    int n_commits;
    int n_excs;

    rob_top #(
        .WB_PORTS (WB_PORTS)
    ) rob_top_i (
        .clk       (clk),
        .rst       (rst),
        .dis       (dis),
        .wb        (wb),
        .alloc_idx (alloc_idx),
        .full      (full),
        .commit    (commit),
        .exc       (exc)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            idx_errs++;
            $display("ERR t=%0t %s: exp %0b:%0d got %0b:%0d",
                     $time, name, exp.dir, exp.idx, got.dir, got.idx);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            full_errs++;
            $display("ERR t=%0t %s: exp %0b got %0b", $time, name, exp, got);
        end
    endtask

    task automatic check_commit(input commit_bus_t got, input commit_bus_t exp);
        if (got.en !== exp.en || got.num !== exp.num) begin
            commit_errs++;
            $display("ERR t=%0t commit.en/num: exp %b/%0d got %b/%0d",
                     $time, exp.en, exp.num, got.en, got.num);
        end
        check_idx("commit.idx", got.idx, exp.idx);
        // payload fields only matter on slots that retire
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            if (exp.en[k] && (got.we[k] !== exp.we[k] || got.vrd[k] !== exp.vrd[k]
                              || got.prd[k] !== exp.prd[k])) begin
                commit_errs++;
                $display("ERR t=%0t commit slot %0d we/vrd/prd: exp %0b/%0d/%0d got %0b/%0d/%0d",
                         $time, k, exp.we[k], exp.vrd[k], exp.prd[k],
                         got.we[k], got.vrd[k], got.prd[k]);
            end
        end
    endtask

    task automatic check_exc(input exc_report_t got, input exc_report_t exp);
        if (got.en !== exp.en) begin
            exc_errs++;
            $display("ERR t=%0t exc.en: exp %0b got %0b", $time, exp.en, got.en);
        end else if (exp.en) begin
            check_idx("exc.idx", got.idx, exp.idx);
            if (got.exccode !== exp.exccode) begin
                exc_errs++;
                $display("ERR t=%0t exc.exccode: exp %0h got %0h",
                         $time, exp.exccode, got.exccode);
            end
        end
    endtask

    // one clock: drive at the falling edge, update the model at the rising edge
    task automatic run_cycle(input bit allow_dis);
        dis_req_t               d;
        wb_req_t [WB_PORTS-1:0] w;
        int                     wpos [WB_PORTS];
        int                     cand [$];
        int                     j;
        int                     n;
        bit                     exp_full;
        bit                     accept;
        bit                     live;
        commit_bus_t            exp_c;
        exc_report_t            exp_e;
        entry_t                 e;

        @(negedge clk);
        d = '0;
        if (allow_dis) begin
            d.valid_num = NUM_W'($urandom_range(0, DISPATCH_WIDTH));
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                d.payload[i] = rob_payload_t'(($bits(rob_payload_t))'($urandom));
            end
        end
        w = '0;
        for (int i = 0; i < q.size(); i++) begin
            if (!q[i].done) begin
                cand.push_back(i);
            end
        end
        for (int p = 0; p < WB_PORTS; p++) begin
            wpos[p] = -1;
            if (cand.size() > 0 && $urandom_range(0, 1) == 1) begin
                j = $urandom_range(0, cand.size() - 1);
                wpos[p] = cand[j];
                cand.delete(j);
                w[p].en = 1'b1;
                w[p].idx = q[wpos[p]].idx;
                // roughly one writeback in ten raises an exception
                if ($urandom_range(0, 9) == 0) begin
                    w[p].exccode = EXC_WIDTH'($urandom_range(0, 14));
                end else begin
                    w[p].exccode = EXC_NONE;
                end
            end
        end
        dis = d;
        wb = w;
        exp_full = (ROB_SIZE - q.size()) < int'(d.valid_num);
        accept = !exp_full && (d.valid_num != '0);
        #1;
        check_bit("full", full, exp_full);
        check_idx("alloc_idx", alloc_idx, mtail);

        @(posedge clk);
        // group selected from the state just before this edge
        exp_c = '0;
        exp_e = '0;
        exp_c.idx = mhead;
        n = 0;
        live = 1'b1;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            if (live && k < q.size() && q[k].done) begin
                exp_c.en[k] = 1'b1;
                exp_c.we[k] = q[k].pl.we;
                exp_c.vrd[k] = q[k].pl.vrd;
                exp_c.prd[k] = q[k].pl.prd;
                n++;
                if (q[k].code != EXC_NONE) begin
                    exp_c.we[k] = 1'b0;
                    exp_e.en = 1'b1;
                    exp_e.idx = q[k].idx;
                    exp_e.exccode = q[k].code;
                    live = 1'b0;
                end
            end else begin
                live = 1'b0;
            end
        end
        exp_c.num = NUM_W'(n);
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wpos[p] >= 0) begin
                q[wpos[p]].done = 1'b1;
                q[wpos[p]].code = w[p].exccode;
            end
        end
        for (int k = 0; k < n; k++) begin
            void'(q.pop_front());
        end
        mhead = mhead + ($bits(rob_idx_t))'(n);
        if (accept) begin
            for (int i = 0; i < int'(d.valid_num); i++) begin
                e.idx = mtail + ($bits(rob_idx_t))'(i);
                e.pl = d.payload[i];
                e.done = 1'b0;
                e.code = EXC_NONE;
                q.push_back(e);
            end
            mtail = mtail + ($bits(rob_idx_t))'(d.valid_num);
        end
        n_commits += n;
        if (exp_e.en) begin
            n_excs++;
        end
        #1;
        check_commit(commit, exp_c);
        check_exc(exc, exp_e);
    endtask

    initial begin
        int drain_cycles;

        rst = 1'b1;
        dis = '0;
        wb = '0;
        mhead = '0;
        mtail = '0;
        void'($urandom(82));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit("full", full, 1'b0);
        check_idx("alloc_idx", alloc_idx, '0);
        check_commit(commit, '0);
        check_exc(exc, '0);

        for (int c = 0; c < STIM_CYCLES; c++) begin
            run_cycle(1'b1);
        end

        // no more dispatch, keep writing back until everything retires
        drain_cycles = 0;
        while (q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            run_cycle(1'b0);
            drain_cycles++;
        end
        if (q.size() != 0) begin
            stall_errs++;
            $display("commit stalled: %0d entries still allocated after %0d drain cycles",
                     q.size(), DRAIN_LIMIT);
        end

        $display("retired %0d, exceptions %0d, errors idx %0d commit %0d exc %0d full %0d stall %0d",
                 n_commits, n_excs, idx_errs, commit_errs, exc_errs, full_errs, stall_errs);
        if (idx_errs + commit_errs + exc_errs + full_errs + stall_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rob_pkg.sv
rob_ctrl.sv
rob_payload_ram.sv
rob_status.sv
rob_commit_sel.sv
rob_top.sv
tb_rob.sv

// ==== Bender.yml ====
package:
  name: rob

sources:
  - rob_pkg.sv
  - rob_ctrl.sv
  - rob_payload_ram.sv
  - rob_status.sv
  - rob_commit_sel.sv
  - rob_top.sv
  - target: test
    files:
      - tb_rob.sv
